/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/pcs_decoder.sv */
`timescale 1ns/10ps

module pcs_decoder
  import phy_pkg::*;
(
  input  logic        ref_clk,
  input  logic        rst_n,
  input  code_group_t code,
  input  logic        code_strobe,
  input  logic        link_valid,
  output mac_word_t   rx_word,
  output rx_status_t  rx_status,
  output logic        rx_word_strobe,
  output logic        decode_error
);

  int unsigned ones_6b;
  int unsigned ones_4b;
  logic        rd;
  logic        rd_mid;
  logic        rd_next;
  logic        k28;
  logic [3:0]  sub_4b_adj;
  logic [4:0]  dec_5b;
  logic [2:0]  dec_3b;
  logic        valid_6b;
  logic        valid_4b;
  logic        dec_k;
  logic        code_err;
  logic        disp_err;

  assign ones_6b = $countones(code.split.sub_6b);
  assign ones_4b = $countones(code.split.sub_4b);

  ////////////////////
  // 6b lookup
  ////////////////////

  always_comb begin
    valid_6b = 1'b1;
    case (code.split.sub_6b)
      6'b100111, 6'b011000: dec_5b = 5'd0;
      6'b011101, 6'b100010: dec_5b = 5'd1;
      6'b101101, 6'b010010: dec_5b = 5'd2;
      6'b110001:            dec_5b = 5'd3;
      6'b110101, 6'b001010: dec_5b = 5'd4;
      6'b101001:            dec_5b = 5'd5;
      6'b011001:            dec_5b = 5'd6;
      6'b111000, 6'b000111: dec_5b = 5'd7;
      6'b111001, 6'b000110: dec_5b = 5'd8;
      6'b100101:            dec_5b = 5'd9;
      6'b010101:            dec_5b = 5'd10;
      6'b110100:            dec_5b = 5'd11;
      6'b001101:            dec_5b = 5'd12;
      6'b101100:            dec_5b = 5'd13;
      6'b011100:            dec_5b = 5'd14;
      6'b010111, 6'b101000: dec_5b = 5'd15;
      6'b011011, 6'b100100: dec_5b = 5'd16;
      6'b100011:            dec_5b = 5'd17;
      6'b010011:            dec_5b = 5'd18;
      6'b110010:            dec_5b = 5'd19;
      6'b001011:            dec_5b = 5'd20;
      6'b101010:            dec_5b = 5'd21;
      6'b011010:            dec_5b = 5'd22;
      6'b111010, 6'b000101: dec_5b = 5'd23;
      6'b110011, 6'b001100: dec_5b = 5'd24;
      6'b100110:            dec_5b = 5'd25;
      6'b010110:            dec_5b = 5'd26;
      6'b110110, 6'b001001: dec_5b = 5'd27;
      6'b001110, 6'b001111, 6'b110000: dec_5b = 5'd28;
      6'b101110, 6'b010001: dec_5b = 5'd29;
      6'b011110, 6'b100001: dec_5b = 5'd30;
      6'b101011, 6'b010100: dec_5b = 5'd31;
      default: begin
        dec_5b   = 5'd0;
        valid_6b = 1'b0;
      end
    endcase
  end

  ////////////////////
  // 4b lookup
  ////////////////////

  // K28 with positive disparity is the full inverse of its negative form
  assign k28        = (code.split.sub_6b == 6'b001111) || (code.split.sub_6b == 6'b110000);
  assign sub_4b_adj = (code.split.sub_6b == 6'b110000) ? ~code.split.sub_4b : code.split.sub_4b;

  always_comb begin
    valid_4b = 1'b1;
    case (sub_4b_adj)
      4'b1011, 4'b0100: dec_3b = 3'd0;
      4'b1001:          dec_3b = 3'd1;
      4'b0101:          dec_3b = 3'd2;
      4'b1100, 4'b0011: dec_3b = 3'd3;
      4'b1101, 4'b0010: dec_3b = 3'd4;
      4'b1010:          dec_3b = 3'd5;
      4'b0110:          dec_3b = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: dec_3b = 3'd7;
      default: begin
        dec_3b   = 3'd0;
        valid_4b = 1'b0;
      end
    endcase
  end

  // Twelve control groups: K28.0 to K28.7 plus K23/27/29/30.7 using A7
  assign dec_k = k28 ||
                 ((code.split.sub_4b == 4'b0111 || code.split.sub_4b == 4'b1000) &&
                  (dec_5b == 5'd23 || dec_5b == 5'd27 || dec_5b == 5'd29 || dec_5b == 5'd30));

  assign code_err = !valid_6b || !valid_4b ||
                    (ones_6b + ones_4b < 4) || (ones_6b + ones_4b > 6);

  ////////////////////
  // Running disparity
  ////////////////////

  always_comb begin
    disp_err = 1'b0;
    if (rd && (ones_6b > 3 || code.split.sub_6b == 6'b111000)) begin
      disp_err = 1'b1;
    end
    if (!rd && (ones_6b < 3 || code.split.sub_6b == 6'b000111)) begin
      disp_err = 1'b1;
    end
    rd_mid = (ones_6b == 3) ? rd : (ones_6b > 3);
    if (rd_mid && (ones_4b > 2 || code.split.sub_4b == 4'b1100)) begin
      disp_err = 1'b1;
    end
    if (!rd_mid && (ones_4b < 2 || code.split.sub_4b == 4'b0011)) begin
      disp_err = 1'b1;
    end
    // Unbalanced blocks force the disparity, so it resyncs by itself
    rd_next = (ones_4b == 2) ? rd_mid : (ones_4b > 2);
  end

  assign decode_error = code_strobe && code_err;

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      rd             <= 1'b0;
      rx_word_strobe <= 1'b0;
    end else begin
      rx_word_strobe <= code_strobe && link_valid;
      if (code_strobe) begin
        rd <= rd_next;
      end
    end
  end

  always_ff @(posedge ref_clk) begin
    if (code_strobe) begin
      rx_word.data              <= {dec_3b, dec_5b};
      rx_word.k                 <= dec_k;
      rx_status.decode_error    <= code_err;
      rx_status.disparity_error <= disp_err;
    end
  end

endmodule

/* hdl/pcs_encoder.sv */
`timescale 1ns/10ps

module pcs_encoder
  import phy_pkg::*;
(
  input  logic        ref_clk,
  input  logic        rst_n,
  input  logic        word_strobe,
  input  mac_word_t   mac_tx,
  input  logic        mac_data_en,
  output code_group_t code
);

  mac_word_t   sel_word;
  logic [4:0]  d5;
  logic [2:0]  d3;
  logic [5:0]  neg_6b;
  logic [5:0]  enc_6b;
  logic [3:0]  neg_4b;
  logic [3:0]  enc_4b;
  logic        rd;
  logic        rd_eff;
  logic        rd_mid;
  logic        rd_next;
  logic        unb_6b;
  logic        unb_4b;
  logic        use_alt;
  code_group_t enc_code;

  // Idle comma whenever the MAC has nothing to send
  always_comb begin
    if (mac_data_en) begin
      sel_word = mac_tx;
    end else begin
      sel_word.data = K28_5_BYTE;
      sel_word.k    = 1'b1;
    end
  end

  assign d5 = sel_word.data[4:0];
  assign d3 = sel_word.data[7:5];

  ////////////////////
  // 5b/6b
  ////////////////////

  // Negative disparity column, abcdei
  always_comb begin
    case (d5)
      5'd0:  neg_6b = 6'b100111;
      5'd1:  neg_6b = 6'b011101;
      5'd2:  neg_6b = 6'b101101;
      5'd3:  neg_6b = 6'b110001;
      5'd4:  neg_6b = 6'b110101;
      5'd5:  neg_6b = 6'b101001;
      5'd6:  neg_6b = 6'b011001;
      5'd7:  neg_6b = 6'b111000;
      5'd8:  neg_6b = 6'b111001;
      5'd9:  neg_6b = 6'b100101;
      5'd10: neg_6b = 6'b010101;
      5'd11: neg_6b = 6'b110100;
      5'd12: neg_6b = 6'b001101;
      5'd13: neg_6b = 6'b101100;
      5'd14: neg_6b = 6'b011100;
      5'd15: neg_6b = 6'b010111;
      5'd16: neg_6b = 6'b011011;
      5'd17: neg_6b = 6'b100011;
      5'd18: neg_6b = 6'b010011;
      5'd19: neg_6b = 6'b110010;
      5'd20: neg_6b = 6'b001011;
      5'd21: neg_6b = 6'b101010;
      5'd22: neg_6b = 6'b011010;
      5'd23: neg_6b = 6'b111010;
      5'd24: neg_6b = 6'b110011;
      5'd25: neg_6b = 6'b100110;
      5'd26: neg_6b = 6'b010110;
      5'd27: neg_6b = 6'b110110;
      5'd28: neg_6b = sel_word.k ? 6'b001111 : 6'b001110;
      5'd29: neg_6b = 6'b101110;
      5'd30: neg_6b = 6'b011110;
      default: neg_6b = 6'b101011;
    endcase
  end

  // Control groups are built at negative disparity, then inverted whole
  assign rd_eff = sel_word.k ? 1'b0 : rd;
  assign unb_6b = ($countones(neg_6b) != 3);
  assign enc_6b = (rd_eff && (unb_6b || d5 == 5'd7)) ? ~neg_6b : neg_6b;
  assign rd_mid = unb_6b ? ~rd_eff : rd_eff;

  ////////////////////
  // 3b/4b
  ////////////////////

  // A7 avoids a run of five after sub-blocks ending in ii or ee
  assign use_alt = (d3 == 3'd7) &&
                   (sel_word.k ||
                    (!rd_mid && (d5 == 5'd17 || d5 == 5'd18 || d5 == 5'd20)) ||
                    (rd_mid && (d5 == 5'd11 || d5 == 5'd13 || d5 == 5'd14)));

  always_comb begin
    case (d3)
      3'd0:    neg_4b = 4'b1011;
      3'd1:    neg_4b = 4'b1001;
      3'd2:    neg_4b = 4'b0101;
      3'd3:    neg_4b = 4'b1100;
      3'd4:    neg_4b = 4'b1101;
      3'd5:    neg_4b = 4'b1010;
      3'd6:    neg_4b = 4'b0110;
      default: neg_4b = use_alt ? 4'b0111 : 4'b1110;
    endcase
  end

  assign unb_4b = ($countones(neg_4b) != 2);
  assign enc_4b = (rd_mid && (unb_4b || d3 == 3'd3)) ? ~neg_4b : neg_4b;

  always_comb begin
    enc_code.split.sub_6b = enc_6b;
    enc_code.split.sub_4b = enc_4b;
    if (sel_word.k && rd) begin
      enc_code.bits = ~enc_code.bits;
    end
  end

  // Disparity flips on every unbalanced word
  assign rd_next = rd ^ ($countones(enc_code.bits) != 5);

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      rd   <= 1'b0;
      code <= '0;
    end else if (word_strobe) begin
      rd   <= rd_next;
      code <= enc_code;
    end
  end

endmodule

/* hdl/phy_pkg.sv */
package phy_pkg;

  ////////////////////
  // Code group
  ////////////////////

  // Bit a of the code group sits in the MSB and goes on the line first
  typedef struct packed {
    logic [5:0] sub_6b;
    logic [3:0] sub_4b;
  } code_split_t;

  // One 10-bit word, read whole or split into its 6b and 4b sub-blocks
  typedef union packed {
    logic [9:0]  bits;
    code_split_t split;
  } code_group_t;

  ////////////////////
  // MAC side
  ////////////////////

  typedef struct packed {
    logic [7:0] data;
    logic       k;
  } mac_word_t;

  typedef struct packed {
    logic decode_error;
    logic disparity_error;
  } rx_status_t;

  ////////////////////
  // Comma constants
  ////////////////////

  // K28.5 as sent with negative and positive running disparity
  localparam code_group_t K28_5_NEG = 10'b0011111010;
  localparam code_group_t K28_5_POS = 10'b1100000101;

  // Idle control byte
  localparam logic [7:0] K28_5_BYTE = 8'hBC;

endpackage

/* hdl/phy_top.sv */
`timescale 1ns/10ps

module phy_top
  import phy_pkg::*;
#(
  parameter int unsigned COMMA_NUMBER = 4
) (
  input  logic       ref_clk,
  input  logic       rst_n,
  input  mac_word_t  mac_tx,
  input  logic       mac_data_en,
  output logic       tx_word_strobe,
  input  logic       rx_polarity,
  output logic       tx_out_p,
  output logic       tx_out_n,
  input  logic       rx_in,
  output mac_word_t  rx_word,
  output rx_status_t rx_status,
  output logic       rx_valid,
  output logic       rx_word_strobe
);

  code_group_t tx_code;
  code_group_t aligned_code;
  logic        aligned_strobe;
  logic        decode_error;

  ////////////////////
  // Transmit path
  ////////////////////

  pcs_encoder u_pcs_encoder (
    .ref_clk     (ref_clk),
    .rst_n       (rst_n),
    .word_strobe (tx_word_strobe),
    .mac_tx      (mac_tx),
    .mac_data_en (mac_data_en),
    .code        (tx_code)
  );

  pma_tx u_pma_tx (
    .ref_clk     (ref_clk),
    .rst_n       (rst_n),
    .code        (tx_code),
    .word_strobe (tx_word_strobe),
    .tx_out_p    (tx_out_p),
    .tx_out_n    (tx_out_n)
  );

  ////////////////////
  // Receive path
  ////////////////////

  pma_rx #(
    .COMMA_NUMBER (COMMA_NUMBER)
  ) u_pma_rx (
    .ref_clk        (ref_clk),
    .rst_n          (rst_n),
    .rx_in          (rx_in),
    .rx_polarity    (rx_polarity),
    .decode_error   (decode_error),
    .aligned_code   (aligned_code),
    .aligned_strobe (aligned_strobe),
    .rx_valid       (rx_valid)
  );

  pcs_decoder u_pcs_decoder (
    .ref_clk        (ref_clk),
    .rst_n          (rst_n),
    .code           (aligned_code),
    .code_strobe    (aligned_strobe),
    .link_valid     (rx_valid),
    .rx_word        (rx_word),
    .rx_status      (rx_status),
    .rx_word_strobe (rx_word_strobe),
    .decode_error   (decode_error)
  );

endmodule

/* hdl/pma_rx.sv */
`timescale 1ns/10ps

module pma_rx
  import phy_pkg::*;
#(
  parameter int unsigned COMMA_NUMBER = 4
) (
  input  logic        ref_clk,
  input  logic        rst_n,
  input  logic        rx_in,
  input  logic        rx_polarity,
  input  logic        decode_error,
  output code_group_t aligned_code,
  output logic        aligned_strobe,
  output logic        rx_valid
);

  localparam int unsigned CNT_W = $clog2(COMMA_NUMBER + 1);

  logic             rx_bit;
  code_group_t      window;
  logic [3:0]       phase_cnt;
  logic [CNT_W-1:0] comma_cnt;
  logic             comma_pulse;
  logic             at_boundary;
  logic             misaligned;

  assign rx_bit = rx_in ^ rx_polarity;

  // Oldest bit ends up in the MSB, matching the transmit order
  always_ff @(posedge ref_clk) begin
    window.bits <= {window.bits[8:0], rx_bit};
  end

  ////////////////////
  // Comma alignment
  ////////////////////

  assign comma_pulse = (window.bits == K28_5_NEG.bits) || (window.bits == K28_5_POS.bits);
  assign at_boundary = (phase_cnt == 4'd9);
  assign misaligned  = comma_pulse && !at_boundary;

  // A comma anywhere becomes the new word boundary
  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      phase_cnt <= 4'd0;
    end else if (comma_pulse || at_boundary) begin
      phase_cnt <= 4'd0;
    end else begin
      phase_cnt <= phase_cnt + 4'd1;
    end
  end

  assign aligned_strobe = comma_pulse || at_boundary;
  assign aligned_code   = window;

  ////////////////////
  // Link qualification
  ////////////////////

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      comma_cnt <= '0;
      rx_valid  <= 1'b0;
    end else if (misaligned || decode_error) begin
      comma_cnt <= '0;
      rx_valid  <= 1'b0;
    end else if (at_boundary && comma_pulse) begin
      // Saturate once the link is up
      if (comma_cnt != CNT_W'(COMMA_NUMBER)) begin
        comma_cnt <= comma_cnt + CNT_W'(1);
      end
      if (comma_cnt >= CNT_W'(COMMA_NUMBER - 1)) begin
        rx_valid <= 1'b1;
      end
    end
  end

endmodule

/* hdl/pma_tx.sv */
`timescale 1ns/10ps

module pma_tx
  import phy_pkg::*;
(
  input  logic        ref_clk,
  input  logic        rst_n,
  input  code_group_t code,
  output logic        word_strobe,
  output logic        tx_out_p,
  output logic        tx_out_n
);

  logic [3:0] bit_cnt;
  logic [9:0] shift_reg;

  // One strobe every ten bit times
  assign word_strobe = (bit_cnt == 4'd9);

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      bit_cnt <= 4'd0;
    end else if (word_strobe) begin
      bit_cnt <= 4'd0;
    end else begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // Serializer, MSB first so bit a leads
  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      shift_reg <= '0;
    end else if (word_strobe) begin
      shift_reg <= code.bits;
    end else begin
      shift_reg <= {shift_reg[8:0], 1'b0};
    end
  end

  assign tx_out_p = shift_reg[9];
  assign tx_out_n = ~shift_reg[9];

endmodule

/* sources.f */
hdl/phy_pkg.sv
hdl/pcs_encoder.sv
hdl/pma_tx.sv
hdl/pma_rx.sv
hdl/pcs_decoder.sv
hdl/phy_top.sv
tests/tb_top.sv

/* tests/tb_top.sv */
`timescale 1ns/10ps

module tb_top
  import phy_pkg::*;
;

  logic        clk;
  logic        rst_n;
  mac_word_t   mac_tx;
  logic        mac_data_en;
  logic        tx_word_strobe;
  logic        rx_polarity;
  logic        tx_out_p;
  logic        tx_out_n;
  logic        rx_in;
  mac_word_t   rx_word;
  rx_status_t  rx_status;
  logic        rx_valid;
  logic        rx_word_strobe;

  logic        invert;
  logic        flip;
  logic        inject_window;
  logic        err_seen;
  logic        prev_valid;
  logic        last_bit;
  int          run_len;
  int          mismatch_count;
  int          fail_count;
  int          seed;
  mac_word_t   sent_q[$];
  mac_word_t   exp_word;

  always #50 clk = ~clk;

  // Loopback with polarity swap and single-bit error injection
  assign rx_in = tx_out_p ^ invert ^ flip;

  phy_top #(
    .COMMA_NUMBER (4)
  ) u_dut (
    .ref_clk        (clk),
    .rst_n          (rst_n),
    .mac_tx         (mac_tx),
    .mac_data_en    (mac_data_en),
    .tx_word_strobe (tx_word_strobe),
    .rx_polarity    (rx_polarity),
    .tx_out_p       (tx_out_p),
    .tx_out_n       (tx_out_n),
    .rx_in          (rx_in),
    .rx_word        (rx_word),
    .rx_status      (rx_status),
    .rx_valid       (rx_valid),
    .rx_word_strobe (rx_word_strobe)
  );

  ////////////////////
  // Line checks
  ////////////////////

  assert property (@(posedge clk) disable iff (!rst_n) tx_out_n == !tx_out_p)
    else begin
      mismatch_count++;
      $display("Mismatch at %0t: tx_out_n is %b, expected %b", $time, tx_out_n, !tx_out_p);
    end

  // Run length of equal bits on the line, checked while the link is up
  always @(posedge clk) begin
    if (!rst_n) begin
      run_len = 0;
    end else if (tx_out_p == last_bit) begin
      run_len++;
    end else begin
      run_len = 1;
    end
    last_bit = tx_out_p;
    if (rst_n && rx_valid) begin
      assert (run_len <= 5) else begin
        fail_count++;
        $display("Line held %0d equal bits in a row at %0t", run_len, $time);
      end
    end
  end

  ////////////////////
  // Scoreboard
  ////////////////////

  always @(negedge clk) begin
    if (rst_n && inject_window && prev_valid && !rx_valid) begin
      err_seen = 1'b1;
    end
    prev_valid = rx_valid;
    if (rst_n && rx_word_strobe) begin
      if (inject_window) begin
        if (rx_status != '0) begin
          err_seen = 1'b1;
        end
      end else if (rx_word.k && rx_word.data == K28_5_BYTE) begin
        assert (rx_status == '0) else begin
          mismatch_count++;
          $display("Mismatch at %0t: rx_status got %b expected 00 on an idle comma",
                   $time, rx_status);
        end
      end else if (sent_q.size() == 0) begin
        fail_count++;
        $display("Unexpected word %h k=%b received at %0t", rx_word.data, rx_word.k, $time);
      end else begin
        exp_word = sent_q.pop_front();
        assert (rx_word.data == exp_word.data) else begin
          mismatch_count++;
          $display("Mismatch at %0t: rx_word.data got %h expected %h",
                   $time, rx_word.data, exp_word.data);
        end
        assert (rx_word.k == exp_word.k) else begin
          mismatch_count++;
          $display("Mismatch at %0t: rx_word.k got %b expected %b",
                   $time, rx_word.k, exp_word.k);
        end
        assert (rx_status == '0) else begin
          mismatch_count++;
          $display("Mismatch at %0t: rx_status got %b expected 00", $time, rx_status);
        end
      end
    end
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  // Present a word and return on the edge where the encoder takes it
  task automatic send_word(input mac_word_t w, input logic en);
    int n;
    n = 0;
    mac_tx      <= w;
    mac_data_en <= en;
    @(posedge clk);
    while (!tx_word_strobe && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!tx_word_strobe) begin
      fail_count++;
      $display("No transmit word strobe within 20 cycles at %0t", $time);
    end else if (en && !(w.k && w.data == K28_5_BYTE)) begin
      sent_q.push_back(w);
    end
  endtask

  task automatic wait_link(input int max_cycles);
    int n;
    n = 0;
    while (!rx_valid && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (!rx_valid) begin
      fail_count++;
      $display("rx_valid did not rise within %0d cycles at %0t", max_cycles, $time);
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    mac_data_en <= 1'b0;
    while (sent_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (sent_q.size() != 0) begin
      fail_count++;
      $display("%0d sent words never came back by %0t", sent_q.size(), $time);
    end
  endtask

  task automatic random_data(input int count);
    mac_word_t w;
    for (int i = 0; i < count; i++) begin
      w.data = 8'($random(seed));
      w.k    = 1'b0;
      send_word(w, ($random(seed) & 3) != 0);
    end
    wait_drain(400);
  endtask

  // K28.0 to K28.6, then K23.7, K27.7, K29.7, K30.7 and K28.7
  task automatic control_codes();
    logic [7:0] ctrl [12];
    ctrl = '{8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
             8'hDC, 8'hF7, 8'hFB, 8'hFD, 8'hFE, 8'hFC};
    for (int i = 0; i < 12; i++) begin
      send_word('{data: ctrl[i], k: 1'b1}, 1'b1);
    end
    wait_drain(400);
  endtask

  task automatic inject_error();
    int n;
    err_seen      = 1'b0;
    inject_window = 1'b1;
    send_word('{data: 8'hB5, k: 1'b0}, 1'b1);
    mac_data_en <= 1'b0;
    // Bit a of that word is on the line ten cycles later
    repeat (10) @(posedge clk);
    flip <= 1'b1;
    @(posedge clk);
    flip <= 1'b0;
    n = 0;
    while (!err_seen && n < 40) begin
      @(posedge clk);
      n++;
    end
    if (!err_seen) begin
      fail_count++;
      $display("Flipped line bit raised no error flag and kept rx_valid at %0t", $time);
    end
    repeat (40) @(posedge clk);
    sent_q.delete();
    wait_link(400);
    @(posedge clk);
    inject_window = 1'b0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    mac_tx         = '0;
    mac_data_en    = 1'b0;
    rx_polarity    = 1'b0;
    invert         = 1'b0;
    flip           = 1'b0;
    inject_window  = 1'b0;
    err_seen       = 1'b0;
    prev_valid     = 1'b0;
    last_bit       = 1'b0;
    run_len        = 0;
    mismatch_count = 0;
    fail_count     = 0;
    seed           = 32'h3518_c0aa;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Idle link comes up on commas alone
    wait_link(400);
    repeat (60) @(posedge clk);
    random_data(200);
    control_codes();

    // Inverted line, corrected on the receive side
    @(posedge clk);
    invert      <= 1'b1;
    rx_polarity <= 1'b1;
    repeat (60) @(posedge clk);
    wait_link(400);
    random_data(200);

    inject_error();
    random_data(50);
    repeat (20) @(posedge clk);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
